// File: common/game_pkg.sv
package game_pkg;

    // Sound request from the game controller to the tone generator
    typedef enum logic [2:0] {
        snd_off  = 3'd0,  // Silence while LEDs follow the buttons
        snd_btn0 = 3'd1,
        snd_btn1 = 3'd2,
        snd_btn2 = 3'd3,
        snd_btn3 = 3'd4,
        snd_fail = 3'd5,  // Low buzz with all LEDs
        snd_win  = 3'd6   // High tone with all LEDs
    } sound_mode_e;

    // Longest sequence the game will ask for
    localparam int max_len = 31;

    // Nonzero start value of the sequence LFSR
    localparam logic [15:0] lfsr_seed = 16'hb5a3;

endpackage

// File: common/panel_pkg.sv
package panel_pkg;

    // One display word read either as a score or as a picture
    typedef union packed {
        logic [4:0] score;           // Number view from 0 to 31
        struct packed {
            logic       blank;       // Nothing lit
            logic [3:0] bars;        // [1:0] ones digit, [3:2] tens digit
        } pic;
    } display_word_u;

    // Middle bar of the picture view
    localparam logic [6:0] seg_g = 7'b1000000;

    // Digit patterns with segment a in bit 0
    localparam logic [6:0] seg_digit [10] = '{
        7'b0111111,  // 0
        7'b0000110,  // 1
        7'b1011011,  // 2
        7'b1001111,  // 3
        7'b1100110,  // 4
        7'b1101101,  // 5
        7'b1111101,  // 6
        7'b0000111,  // 7
        7'b1111111,  // 8
        7'b1101111   // 9
    };

    // All four bars shown after a wrong button
    localparam display_word_u fail_picture = 5'b01111;

endpackage

// File: buttons/button_debounce.sv
`timescale 1ns/1ps

module button_debounce #(
    parameter int DEBOUNCE_TICKS = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tick,
    input  logic [3:0] raw_buttons,
    output logic [3:0] button_state,
    output logic       press_strobe,
    output logic [1:0] press_index
);

    localparam int CNT_W = $clog2(DEBOUNCE_TICKS + 1);

    logic [CNT_W-1:0] stable_cnt [4];  // Ticks the raw level has disagreed
    logic [3:0]       differ;
    logic [3:0]       settle;
    logic [3:0]       rise;

    assign differ = raw_buttons ^ button_state;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            settle[i] = differ[i] && (stable_cnt[i] == CNT_W'(DEBOUNCE_TICKS - 1));
        end
    end

    assign rise         = {4{tick}} & settle & raw_buttons;  // Only new presses
    assign press_strobe = |rise;

    // Lowest button wins a tie
    always_comb begin
        press_index = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (rise[i]) press_index = 2'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            button_state <= 4'b0000;
            for (int i = 0; i < 4; i++) stable_cnt[i] <= '0;
        end else if (tick) begin
            for (int i = 0; i < 4; i++) begin
                if (!differ[i]) begin
                    stable_cnt[i] <= '0;  // Bounce restarts the count
                end else if (settle[i]) begin
                    stable_cnt[i]   <= '0;
                    button_state[i] <= raw_buttons[i];
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    a_strobe_on_tick: assert property (@(posedge clk) disable iff (!rst_n)
        press_strobe |=> $past(tick) && button_state[$past(press_index)]);

endmodule

// File: game/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     tick,
    input  logic                     press_strobe,
    input  logic [1:0]               press_index,
    input  logic                     busy,
    output game_pkg::sound_mode_e    sound_mode,
    output logic                     sound_start,
    output panel_pkg::display_word_u display_word,
    output logic                     graphical
);
    import game_pkg::*;
    import panel_pkg::*;

    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_play   = 3'd1;
    localparam logic [2:0] st_listen = 3'd2;
    localparam logic [2:0] st_win    = 3'd3;
    localparam logic [2:0] st_fail   = 3'd4;

    logic [2:0]  state;
    logic [15:0] lfsr;
    logic [15:0] lfsr_start;   // Replay point of the current game
    logic [4:0]  length;
    logic [4:0]  idx;          // Position in the sequence
    logic [4:0]  score;
    logic        tone_pending; // Tone requested and not yet finished
    logic        win_sent;
    logic [15:0] lfsr_next;
    logic [1:0]  expected;

    function automatic sound_mode_e btn_sound(input logic [1:0] btn);
        return sound_mode_e'(3'(btn) + 3'd1);
    endfunction

    assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    assign expected  = lfsr[1:0];

    always_ff @(posedge clk) begin
        sound_start <= 1'b0;
        if (!rst_n) begin
            state        <= st_idle;
            lfsr         <= lfsr_seed;
            lfsr_start   <= lfsr_seed;
            length       <= 5'd1;
            idx          <= 5'd0;
            score        <= 5'd0;
            tone_pending <= 1'b0;
            win_sent     <= 1'b0;
            sound_mode   <= snd_off;
        end else if (tone_pending) begin
            // busy only rises the clock after the start strobe
            if (!busy && !sound_start) tone_pending <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (press_strobe) begin
                        lfsr_start <= lfsr;  // Free-running value seeds the game
                        length     <= 5'd1;
                        score      <= 5'd0;
                        idx        <= 5'd0;
                        state      <= st_play;
                    end else begin
                        lfsr <= lfsr_next;
                    end
                end
                st_play: begin
                    if (idx == length) begin
                        state <= st_listen;
                        idx   <= 5'd0;
                        lfsr  <= lfsr_start;
                    end else if (tick) begin  // Gap of up to one tick between tones
                        sound_mode   <= btn_sound(expected);
                        sound_start  <= 1'b1;
                        tone_pending <= 1'b1;
                        lfsr         <= lfsr_next;
                        idx          <= idx + 5'd1;
                    end
                end
                st_listen: begin
                    if (press_strobe) begin
                        sound_start  <= 1'b1;
                        tone_pending <= 1'b1;
                        if (press_index == expected) begin
                            sound_mode <= btn_sound(press_index);  // Echo the press
                            lfsr       <= lfsr_next;
                            idx        <= idx + 5'd1;
                            if (idx + 5'd1 == length) begin
                                state    <= st_win;
                                win_sent <= 1'b0;
                            end
                        end else begin
                            sound_mode <= snd_fail;
                            state      <= st_fail;
                        end
                    end
                end
                st_win: begin
                    if (!win_sent) begin
                        sound_mode   <= snd_win;
                        sound_start  <= 1'b1;
                        tone_pending <= 1'b1;
                        win_sent     <= 1'b1;
                        score        <= score + 5'd1;
                    end else if (length == 5'(max_len)) begin
                        state <= st_idle;  // Longest sequence done and score stays up
                    end else begin
                        length <= length + 5'd1;
                        idx    <= 5'd0;
                        lfsr   <= lfsr_start;
                        state  <= st_play;
                    end
                end
                st_fail: begin
                    if (press_strobe) begin
                        score <= 5'd0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign graphical = (state == st_fail);

    always_comb begin
        display_word.score = score;
        if (graphical) display_word = fail_picture;
    end

    a_no_start_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        sound_start |-> !busy);
    a_score_limit: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_win && !win_sent) |-> score < 5'(max_len));

endmodule

// File: verilog/tone_gen.sv
`timescale 1ns/1ps

module tone_gen #(
    parameter int TONE_TICKS = 60
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  tick,
    input  game_pkg::sound_mode_e sound_mode,
    input  logic                  sound_start,
    input  logic [3:0]            button_state,
    output logic [3:0]            leds,
    output logic                  sound,
    output logic                  busy
);
    import game_pkg::*;

    localparam int CNT_W = $clog2(TONE_TICKS + 1);

    sound_mode_e      mode_q;       // Mode of the running tone
    sound_mode_e      idle_mode;
    sound_mode_e      active_mode;
    logic [CNT_W-1:0] tick_cnt;
    logic             half_phase;   // Slows the fail buzz

    always_comb begin
        if (button_state[0])      idle_mode = snd_btn0;
        else if (button_state[1]) idle_mode = snd_btn1;
        else if (button_state[2]) idle_mode = snd_btn2;
        else if (button_state[3]) idle_mode = snd_btn3;
        else                      idle_mode = snd_off;
    end

    assign active_mode = busy ? mode_q : idle_mode;

    always_comb begin
        case (active_mode)
            snd_btn0:          leds = 4'b0001;
            snd_btn1:          leds = 4'b0010;
            snd_btn2:          leds = 4'b0100;
            snd_btn3:          leds = 4'b1000;
            snd_fail, snd_win: leds = 4'b1111;
            default:           leds = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            tick_cnt   <= '0;
            mode_q     <= snd_off;
            sound      <= 1'b0;
            half_phase <= 1'b0;
        end else begin
            if (sound_start) begin
                busy     <= 1'b1;
                mode_q   <= sound_mode;
                tick_cnt <= '0;
            end else if (busy && tick) begin
                if (tick_cnt == CNT_W'(TONE_TICKS - 1)) begin
                    busy     <= 1'b0;  // Last tick of the tone
                    tick_cnt <= '0;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
            if (active_mode == snd_off) begin
                sound      <= 1'b0;
                half_phase <= 1'b0;
            end else if (tick) begin
                half_phase <= ~half_phase;
                if (active_mode != snd_fail || half_phase) sound <= ~sound;
            end
        end
    end

    a_busy_ends_on_tick: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(tick));

endmodule

// File: verilog/seven_seg_mux.sv
`timescale 1ns/1ps

module seven_seg_mux (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     tick,
    input  panel_pkg::display_word_u display_word,
    input  logic                     graphical,
    input  logic                     seg_invert,
    output logic [6:0]               segments,
    output logic [1:0]               digit_sel
);
    import panel_pkg::*;

    logic [3:0] tens;
    logic [3:0] ones;
    logic [6:0] tens_seg;
    logic [6:0] ones_seg;
    logic [1:0] sel_next;
    logic [6:0] seg_raw;

    always_comb begin
        tens     = 4'(display_word.score / 5'd10);
        ones     = 4'(display_word.score % 5'd10);
        tens_seg = seg_digit[tens];
        ones_seg = seg_digit[ones];
        if (graphical) begin
            // Either bar of a digit lights its middle segment
            tens_seg = (|display_word.pic.bars[3:2]) ? seg_g : 7'b0000000;
            ones_seg = (|display_word.pic.bars[1:0]) ? seg_g : 7'b0000000;
            if (display_word.pic.blank) begin
                tens_seg = 7'b0000000;
                ones_seg = 7'b0000000;
            end
        end
    end

    // Pattern is picked for the phase that the next clock shows
    assign sel_next = tick ? {digit_sel[0], digit_sel[1]} : digit_sel;
    assign seg_raw  = sel_next[1] ? tens_seg : ones_seg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit_sel <= 2'b01;                         // Ones digit first
            segments  <= ones_seg ^ {7{seg_invert}};
        end else begin
            digit_sel <= sel_next;
            segments  <= seg_raw ^ {7{seg_invert}};     // Common anode boards need it
        end
    end

endmodule

// File: verilog/simon_top.sv
`timescale 1ns/1ps

module simon_top #(
    parameter int TICK_DIV       = 250,
    parameter int DEBOUNCE_TICKS = 4,
    parameter int TONE_TICKS     = 60
) (
    input  logic [7:0] ui_in,
    output logic [7:0] uo_out,
    input  logic [7:0] uio_in,
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,
    input  logic       ena,
    input  logic       clk,
    input  logic       rst_n
);
    import game_pkg::*;
    import panel_pkg::*;

    localparam int DIV_W = $clog2(TICK_DIV + 1);

    logic [3:0]       raw_buttons;
    logic             seg_invert;
    logic             unused_inputs;
    logic [3:0]       leds;
    logic             sound;
    logic [1:0]       digit_sel;
    logic [6:0]       segments;
    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic [3:0]       button_state;
    logic             press_strobe;
    logic [1:0]       press_index;
    sound_mode_e      sound_mode;
    logic             sound_start;
    logic             busy;
    display_word_u    display_word;
    logic             graphical;

    assign raw_buttons   = ui_in[3:0];
    assign seg_invert    = ui_in[4];
    assign unused_inputs = &{ena, ui_in[7:5], uio_in, 1'b0};  // Pins with no function

    assign uo_out  = {1'b0, digit_sel, sound, leds};
    assign uio_out = {1'b0, segments};
    assign uio_oe  = 8'hff;  // Every IO is an output

    // Slow tick for debounce, tones and display scan
    always_ff @(posedge clk) begin
        tick <= 1'b0;
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (div_cnt == DIV_W'(TICK_DIV - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    button_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) u_debounce (
        .clk(clk), .rst_n(rst_n), .tick(tick), .raw_buttons(raw_buttons),
        .button_state(button_state), .press_strobe(press_strobe), .press_index(press_index)
    );

    game_fsm u_game (
        .clk(clk), .rst_n(rst_n), .tick(tick), .press_strobe(press_strobe),
        .press_index(press_index), .busy(busy), .sound_mode(sound_mode),
        .sound_start(sound_start), .display_word(display_word), .graphical(graphical)
    );

    tone_gen #(.TONE_TICKS(TONE_TICKS)) u_tone (
        .clk(clk), .rst_n(rst_n), .tick(tick), .sound_mode(sound_mode),
        .sound_start(sound_start), .button_state(button_state), .leds(leds),
        .sound(sound), .busy(busy)
    );

    seven_seg_mux u_display (
        .clk(clk), .rst_n(rst_n), .tick(tick), .display_word(display_word),
        .graphical(graphical), .seg_invert(seg_invert), .segments(segments),
        .digit_sel(digit_sel)
    );

endmodule

// File: tests/tb_tasks.svh
localparam logic [6:0] bar_pattern = 7'b1000000;  // Middle segment only

task report_value(input string name, input logic [7:0] actual, input logic [7:0] expected);
    errors++;
    $display("** Error at %0d ns: %s = %b, expected %b", $time, name, actual, expected);
endtask

// Wait until any LED is lit, or until all are dark
task wait_leds(input logic lit);
    int n;
    n = 0;
    while ((|leds) != lit && n < wait_limit) begin
        next_clock();
        n++;
    end
    if ((|leds) != lit) begin
        timeouts++;
        $display("Timeout at %0d ns: LEDs never became %s", $time, lit ? "lit" : "dark");
    end
endtask

task press_button(input int b);
    raw = 4'(1 << b);
    wait_leds(1'b1);
    if (leds !== 4'(1 << b)) report_value("leds", 8'(leds), 8'(4'(1 << b)));
    raw = 4'b0000;
endtask

// Checks each digit_sel phase right after it changes
task check_display(input logic [6:0] ones_pat, input logic [6:0] tens_pat);
    logic [1:0] prev;
    int         n;
    for (int phase = 0; phase < 2; phase++) begin
        prev = digit_sel;
        n    = 0;
        while (digit_sel == prev && n < wait_limit) begin
            next_clock();
            n++;
        end
        if (digit_sel == prev) begin
            timeouts++;
            $display("Timeout at %0d ns: digit_sel stopped alternating", $time);
        end else if (digit_sel == 2'b01) begin
            if (segments !== ones_pat) report_value("segments", 8'(segments), 8'(ones_pat));
        end else if (digit_sel == 2'b10) begin
            if (segments !== tens_pat) report_value("segments", 8'(segments), 8'(tens_pat));
        end else begin
            errors++;
            $display("** Error at %0d ns: digit_sel = %b, expected 01 or 10", $time, digit_sel);
        end
    end
endtask

task check_score(input int s);
    check_display(seg_digit[4'(s % 10)], seg_digit[4'(s / 10)]);
endtask

// Counts sound edges while all four LEDs are lit
task tone_window(output int toggles);
    int   n;
    logic last;
    toggles = 0;
    n       = 0;
    while (leds !== 4'b1111 && n < wait_limit) begin
        next_clock();
        n++;
    end
    if (leds !== 4'b1111) begin
        timeouts++;
        $display("Timeout at %0d ns: all LEDs never lit together", $time);
    end else begin
        last = sound;
        n    = 0;
        while (leds === 4'b1111 && n < wait_limit) begin
            next_clock();
            n++;
            if (leds === 4'b1111 && sound !== last) toggles++;
            last = sound;
        end
    end
endtask

task record_playback(input int len);
    int found;
    for (int k = 0; k < len; k++) begin
        wait_leds(1'b1);
        found = -1;
        for (int b = 0; b < 4; b++) begin
            if (leds == 4'(1 << b)) found = b;
        end
        if (found < 0) begin
            errors++;
            seq[k] = 2'd0;
            $display("** Error at %0d ns: leds = %b, expected one lit", $time, leds);
        end else begin
            seq[k] = 2'(found);
        end
        wait_leds(1'b0);
    end
endtask

task verify_reset_values();
    if (leds !== 4'b0000) report_value("leds", 8'(leds), 8'h00);
    if (sound !== 1'b0) report_value("sound", 8'(sound), 8'h00);
    if (uo_out[7] !== 1'b0) report_value("uo_out[7]", 8'(uo_out[7]), 8'h00);
    if (uio_out[7] !== 1'b0) report_value("uio_out[7]", 8'(uio_out[7]), 8'h00);
    if (uio_oe !== 8'hff) report_value("uio_oe", uio_oe, 8'hff);
    if (digit_sel !== 2'b01) report_value("digit_sel", 8'(digit_sel), 8'h01);
    if (segments !== seg_digit[0]) report_value("segments", 8'(segments), 8'(seg_digit[0]));
    check_score(0);
endtask

task reject_bounce_then_hold();
    int len;
    for (int i = 0; i < noise_bursts; i++) begin
        raw = {random_bit(), random_bit(), random_bit(), random_bit()};
        len = 1 + int'(random_bit()) + int'(random_bit());  // Spans one tick at most
        repeat (len) begin
            next_clock();
            if (leds !== 4'b0000) report_value("leds", 8'(leds), 8'h00);
        end
        raw = 4'b0000;
        repeat (tick_div) begin  // Low across a tick clears the count
            next_clock();
            if (leds !== 4'b0000) report_value("leds", 8'(leds), 8'h00);
        end
    end
    press_button(2);  // Clean hold that also starts a game
    repeat (debounce_ticks * tick_div + 1) next_clock();
endtask

task score_three_rounds();
    int toggles;
    for (int round = 1; round <= 2; round++) begin
        record_playback(round);
        check_score(round - 1);
        for (int k = 0; k < round; k++) begin
            press_button(int'(seq[k]));
            wait_leds(1'b0);
        end
        tone_window(toggles);
        if (toggles < tone_ticks - 1) begin
            errors++;
            $display("Win tone toggled the sound only %0d times", toggles);
        end
    end
    record_playback(3);
    check_score(2);
endtask

task fail_on_wrong_button();
    int wrong;
    int toggles;
    wrong = (int'(seq[0]) + 1) % 4;
    press_button(wrong);
    tone_window(toggles);
    if (toggles == 0 || toggles > tone_ticks / 2) begin
        errors++;
        $display("Fail tone toggled the sound %0d times, not every second tick", toggles);
    end
    check_display(bar_pattern, bar_pattern);
    press_button(0);
    wait_leds(1'b0);
    check_score(0);
endtask

task compare_inverted_segments();
    seg_inv = 1'b1;
    check_display(~seg_digit[0], ~seg_digit[0]);
    seg_inv = 1'b0;
endtask

// File: tests/tb_simon.sv
`timescale 1ns/1ps

module tb_simon;
    import game_pkg::*;
    import panel_pkg::*;

    localparam int tick_div       = 4;
    localparam int debounce_ticks = 2;
    localparam int tone_ticks     = 3;
    localparam int wait_limit     = 4 * (tone_ticks + debounce_ticks + 2) * tick_div;
    localparam int noise_bursts   = 40;
    // About 42 bounded waits over all tests, plus noise bursts and fixed gaps
    localparam int watchdog_clks  = 48 * wait_limit + noise_bursts * 2 * tick_div + 200;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [3:0] raw;             // Raw button pins
    logic       seg_inv;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;
    logic [3:0] leds;
    logic       sound;
    logic [1:0] digit_sel;
    logic [6:0] segments;
    logic [7:0] lfsr_state;
    logic [1:0] seq [max_len];   // Buttons seen during playback
    int         errors;
    int         timeouts;

    assign ui_in     = {3'b000, seg_inv, raw};
    assign leds      = uo_out[3:0];
    assign sound     = uo_out[4];
    assign digit_sel = uo_out[6:5];
    assign segments  = uio_out[6:0];

    simon_top #(
        .TICK_DIV(tick_div),
        .DEBOUNCE_TICKS(debounce_ticks),
        .TONE_TICKS(tone_ticks)
    ) DUT (
        .ui_in(ui_in), .uo_out(uo_out), .uio_in(uio_in), .uio_out(uio_out),
        .uio_oe(uio_oe), .ena(ena), .clk(clk), .rst_n(rst_n)
    );

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_advance(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function logic random_bit();
        lfsr_state = lfsr_advance(lfsr_state);
        return lfsr_state[0];
    endfunction

    task next_clock();
        @(posedge clk);
        #1;  // Outputs settled and inputs change here
    endtask

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (watchdog_clks) @(posedge clk);
        $display("Watchdog expired after %0d clocks, the run is stuck", watchdog_clks);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        ena        = 1'b1;
        raw        = 4'b0000;
        seg_inv    = 1'b0;
        uio_in     = 8'h00;
        lfsr_state = 8'd31;
        errors     = 0;
        timeouts   = 0;
        repeat (10) next_clock();
        rst_n = 1'b1;

        verify_reset_values();
        reject_bounce_then_hold();
        score_three_rounds();
        fail_on_wrong_button();
        compare_inverted_segments();

        $display("Run complete with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+tests
common/game_pkg.sv
common/panel_pkg.sv
buttons/button_debounce.sv
game/game_fsm.sv
verilog/tone_gen.sv
verilog/seven_seg_mux.sv
verilog/simon_top.sv
tests/tb_simon.sv

// File: run.sh
#!/bin/sh
# Build and run the Simon testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_simon -f all.f -o sim_simon; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_simon)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
